// ==== common/drac_pkg.sv ====
// Shared types for the decode-to-issue slice, RV32I base opcodes only
// Queue depth default must stay a power of two of at least 2

package drac_pkg;

    // Meaningful widths
    typedef logic [4:0]  reg_addr_t;    // Architectural register index
    typedef logic [31:0] addr_t;        // Program counter
    typedef logic [31:0] instr_word_t;  // Raw fetched word
    typedef logic [31:0] imm_t;         // Sign-extended immediate
    typedef logic [6:0]  opcode_t;

    // Major opcodes of the RV32I base set
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    typedef enum logic [2:0] {
        ALU_REG,
        ALU_IMM,
        LOAD,
        STORE,
        BRANCH,
        JUMP,       // JAL and JALR
        LUI_AUIPC,
        ILLEGAL     // Any opcode outside the list above
    } instr_kind_t;

    // Decoded instruction, 86 bits
    typedef struct packed {
        logic        valid;
        addr_t       pc;
        instr_kind_t kind;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic        use_rs1;  // Source read, checked against scoreboard
        logic        use_rs2;
        logic        we_rd;    // Never set for x0
        imm_t        imm;
    } instr_t;

    // Record stored in the instruction queue, 90 bits
    typedef struct packed {
        instr_t     instr;
        logic [2:0] funct3;
        logic       funct7_5;  // Picks SUB/SRA from ADD/SRL
    } id_ir_stage_t;

    // Fetch side word, 65 bits
    typedef struct packed {
        logic        valid;
        addr_t       pc;
        instr_word_t word;
    } fetch_t;

    // Writeback pulse that frees one register
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
    } wb_t;

    localparam int unsigned INSTRUCTION_QUEUE_NUM_ENTRIES = 8;

endpackage

// ==== src/decode_stage.sv ====
// Registered RV32I decoder, one word per cycle, no compressed forms
// Output record holds while the queue reports full; fetch must wait on ready

`timescale 1ns/1ps

module decode_stage
    import drac_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  fetch_t       fetch_i,
    input  logic         flush_i,
    input  logic         full_i,     // Queue back-pressure
    output id_ir_stage_t decoded_o
);

    instr_word_t  word;
    opcode_t      opcode;
    imm_t         imm_i;
    imm_t         imm_s;
    imm_t         imm_b;
    imm_t         imm_u;
    imm_t         imm_j;
    id_ir_stage_t dec_d;
    id_ir_stage_t dec_q;

    assign word   = fetch_i.word;
    assign opcode = word[6:0];

    // Immediate formats, sign taken from bit 31
    assign imm_i = {{20{word[31]}}, word[31:20]};
    assign imm_s = {{20{word[31]}}, word[31:25], word[11:7]};
    assign imm_b = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    assign imm_u = {word[31:12], 12'b0};
    assign imm_j = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};

    always_comb begin
        dec_d                = '0;
        dec_d.instr.valid    = fetch_i.valid;
        dec_d.instr.pc       = fetch_i.pc;
        dec_d.instr.rd       = word[11:7];   // Raw fields, used or not
        dec_d.instr.rs1      = word[19:15];
        dec_d.instr.rs2      = word[24:20];
        dec_d.funct3         = word[14:12];
        dec_d.funct7_5       = word[30];

        case (opcode)
            OP_REG: begin
                dec_d.instr.kind    = ALU_REG;
                dec_d.instr.use_rs1 = 1'b1;
                dec_d.instr.use_rs2 = 1'b1;
                dec_d.instr.we_rd   = 1'b1;
            end
            OP_IMM: begin
                dec_d.instr.kind    = ALU_IMM;
                dec_d.instr.use_rs1 = 1'b1;
                dec_d.instr.we_rd   = 1'b1;
                dec_d.instr.imm     = imm_i;
            end
            OP_LOAD: begin
                dec_d.instr.kind    = LOAD;
                dec_d.instr.use_rs1 = 1'b1;
                dec_d.instr.we_rd   = 1'b1;
                dec_d.instr.imm     = imm_i;
            end
            OP_STORE: begin
                dec_d.instr.kind    = STORE;  // Base and data sources, no rd
                dec_d.instr.use_rs1 = 1'b1;
                dec_d.instr.use_rs2 = 1'b1;
                dec_d.instr.imm     = imm_s;
            end
            OP_BRANCH: begin
                dec_d.instr.kind    = BRANCH;
                dec_d.instr.use_rs1 = 1'b1;
                dec_d.instr.use_rs2 = 1'b1;
                dec_d.instr.imm     = imm_b;
            end
            OP_JAL: begin
                dec_d.instr.kind    = JUMP;
                dec_d.instr.we_rd   = 1'b1;   // Link register
                dec_d.instr.imm     = imm_j;
            end
            OP_JALR: begin
                dec_d.instr.kind    = JUMP;
                dec_d.instr.use_rs1 = 1'b1;
                dec_d.instr.we_rd   = 1'b1;
                dec_d.instr.imm     = imm_i;
            end
            OP_LUI, OP_AUIPC: begin
                dec_d.instr.kind    = LUI_AUIPC;
                dec_d.instr.we_rd   = 1'b1;
                dec_d.instr.imm     = imm_u;
            end
            default: begin
                dec_d.instr.kind    = ILLEGAL;  // No register use at all
            end
        endcase

        // Writes to x0 are dropped here so the scoreboard never sees them
        if (dec_d.instr.rd == '0) begin
            dec_d.instr.we_rd = 1'b0;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            dec_q <= '0;
        end else if (flush_i) begin
            dec_q <= '0;                  // Drop the record in flight
        end else if (!full_i) begin
            dec_q <= dec_d;               // Queue takes old record on this edge
        end
    end

    assign decoded_o = dec_q;

endmodule

// ==== instruction_queue/instruction_queue.sv ====
// Circular buffer of decoded records; NUM_ENTRIES must be a power of two >= 2
// Full is reported while reset is asserted, head reads as zero when empty

`timescale 1ns/1ps

module instruction_queue
    import drac_pkg::*;
#(
    parameter int unsigned NUM_ENTRIES = INSTRUCTION_QUEUE_NUM_ENTRIES
) (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  id_ir_stage_t instruction_i,
    input  logic         flush_i,
    input  logic         read_head_i,    // Pops the head at the next edge
    output id_ir_stage_t instruction_o,
    output logic         full_o,
    output logic         empty_o
);

    localparam int unsigned PTR_W = $clog2(NUM_ENTRIES);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   count_t;       // One bit wider than the pointers

    localparam count_t FULL_COUNT = count_t'(NUM_ENTRIES);

    ptr_t         head_q;
    ptr_t         tail_q;
    count_t       count_q;
    logic         write_en;
    logic         read_en;
    id_ir_stage_t buffer_q [NUM_ENTRIES];

    assign write_en = instruction_i.instr.valid & (count_q != FULL_COUNT);
    assign read_en  = read_head_i & (count_q != '0);

    // Storage only, pointers decide what is live
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            buffer_q[tail_q] <= instruction_i;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + ptr_t'(read_en);   // Wraps at NUM_ENTRIES
            tail_q  <= tail_q + ptr_t'(write_en);
            count_q <= count_q + count_t'(write_en) - count_t'(read_en);
        end
    end

    assign empty_o       = (count_q == '0);
    assign full_o        = (count_q == FULL_COUNT) | ~rstn_i;  // Blocks fetch in reset
    assign instruction_o = empty_o ? '0 : buffer_q[head_q];

endmodule

// ==== src/issue_stage.sv ====
// In-order issue from the queue head with a busy-register scoreboard
// Scoreboard survives a flush; writeback of an issued register must still arrive

`timescale 1ns/1ps

module issue_stage
    import drac_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  id_ir_stage_t head_i,
    input  logic         empty_i,
    input  logic         exec_stall_i,
    input  logic         flush_i,
    input  wb_t          wb_i,         // One-cycle pulse per written register
    output logic         read_head_o,
    output id_ir_stage_t issue_o
);

    localparam int unsigned NUM_REGS = 2 ** $bits(reg_addr_t);

    logic [NUM_REGS-1:0] busy_q;     // Bit per register, x0 stays clear
    logic [NUM_REGS-1:0] set_mask;
    logic [NUM_REGS-1:0] clr_mask;
    logic                rs1_busy;
    logic                rs2_busy;
    logic                hazard;
    logic                issue_en;
    id_ir_stage_t        issue_q;

    // RAW check, only sources the instruction really reads
    assign rs1_busy = head_i.instr.use_rs1 & busy_q[head_i.instr.rs1];
    assign rs2_busy = head_i.instr.use_rs2 & busy_q[head_i.instr.rs2];
    assign hazard   = rs1_busy | rs2_busy;

    assign read_head_o = ~empty_i & ~exec_stall_i & ~hazard;

    // A pop in a flush cycle is discarded and must not mark rd
    assign issue_en = read_head_o & ~flush_i;

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (issue_en && head_i.instr.we_rd && head_i.instr.rd != '0) begin
            set_mask[head_i.instr.rd] = 1'b1;
        end
        if (wb_i.valid) begin
            clr_mask[wb_i.rd] = 1'b1;
        end
    end

    // Set applied after clear, so a new writer of the same register wins
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= (busy_q & ~clr_mask) | set_mask;
        end
    end

    // Issue register, valid only in the cycle after a pop
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            issue_q <= '0;
        end else if (issue_en) begin
            issue_q <= head_i;
        end else begin
            issue_q <= '0;         // Covers flush and no-issue cycles
        end
    end

    assign issue_o = issue_q;

endmodule

// ==== src/decode_issue_top.sv ====
// Decode, instruction queue and issue in series; IQ_DEPTH power of two >= 2
// Fetch may only present a word while fetch_ready_o is high

`timescale 1ns/1ps

module decode_issue_top
    import drac_pkg::*;
#(
    parameter int unsigned IQ_DEPTH = INSTRUCTION_QUEUE_NUM_ENTRIES
) (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  fetch_t       fetch_i,
    input  logic         flush_i,
    input  logic         exec_stall_i,
    input  wb_t          wb_i,
    output logic         fetch_ready_o,
    output id_ir_stage_t issue_o
);

    id_ir_stage_t decoded;      // Decode register to queue tail
    id_ir_stage_t iq_head;
    logic         iq_full;
    logic         iq_empty;
    logic         read_head;

    decode_stage i_decode_stage (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .fetch_i   (fetch_i),
        .flush_i   (flush_i),
        .full_i    (iq_full),
        .decoded_o (decoded)
    );

    instruction_queue #(
        .NUM_ENTRIES (IQ_DEPTH)
    ) i_instruction_queue (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instruction_i (decoded),
        .flush_i       (flush_i),
        .read_head_i   (read_head),
        .instruction_o (iq_head),
        .full_o        (iq_full),
        .empty_o       (iq_empty)
    );

    issue_stage i_issue_stage (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .head_i       (iq_head),
        .empty_i      (iq_empty),
        .exec_stall_i (exec_stall_i),
        .flush_i      (flush_i),
        .wb_i         (wb_i),
        .read_head_o  (read_head),
        .issue_o      (issue_o)
    );

    assign fetch_ready_o = ~iq_full;  // Low in reset since full is forced high

endmodule

// ==== sim/clk_rst_gen.sv ====
// Testbench clock and active-low reset, reset released on a falling edge
`timescale 1ns/1ps

module clk_rst_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 2
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o  = 1'b0;
        rstn_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;  // Away from the sampling edge
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== sim/decode_issue_properties.sv ====
// Bound to decode_issue_top; checks queue levels and the issue decision
`timescale 1ns/1ps

module decode_issue_properties
    import drac_pkg::*;
(
    input logic         clk_i,
    input logic         rstn_i,
    input logic         read_head_i,
    input logic         empty_i,
    input logic         full_i,
    input id_ir_stage_t head_i,
    input id_ir_stage_t issue_i,    // Registered issue output
    input logic [31:0]  busy_i      // Issue stage scoreboard
);

    logic [31:0] busy_prev;         // Scoreboard as seen by the last issue decision

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            busy_prev <= '0;
        end else begin
            busy_prev <= busy_i;
        end
    end

    // Never pop an empty slot, a live head always carries a stored record
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        read_head_i |-> head_i.instr.valid)
        else $error("queue popped while empty");

    a_full_xor_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(full_i && empty_i))
        else $error("queue reports full and empty together");

    // What leaves the issue register must not read a register busy at decision time
    a_no_busy_source: assert property (@(posedge clk_i) disable iff (!rstn_i)
        issue_i.instr.valid |-> !(issue_i.instr.use_rs1 && busy_prev[issue_i.instr.rs1])
                             && !(issue_i.instr.use_rs2 && busy_prev[issue_i.instr.rs2]))
        else $error("instruction issued with a busy source");

endmodule

// ==== sim/tb_decode_issue.sv ====
// Table-driven test of decode, queue and issue; writeback returns 3 cycles after issue
`timescale 1ns/1ps

module tb_decode_issue;
    import drac_pkg::*;

    localparam int IQ_DEPTH = 8;
    localparam int N_ROWS   = 17;
    localparam int LIMIT    = N_ROWS * 20 + 200;  // Cycles before timeout

    typedef struct {
        instr_word_t word;
        int          stall;    // exec_stall_i cycles started with this row
        bit          flush;    // Flush pulse before the word
        instr_kind_t kind;
        reg_addr_t   rd, rs1, rs2;
        imm_t        imm;
        bit          u1, u2, we;
        logic [2:0]  f3;       // funct3 field
        bit          f7;       // funct7 bit 5
    } row_t;

    // Expected fields worked out by hand from the RV32I formats
    row_t tbl [N_ROWS] = '{
        '{32'h00500293, 30, 0, ALU_IMM,   5,  0,  5,  32'd5,        1, 0, 1, 0, 0},  // addi x5,x0,5
        '{32'h00528333, 0,  0, ALU_REG,   6,  5,  5,  32'd0,        1, 1, 1, 0, 0},  // add  x6,x5,x5
        '{32'h405303B3, 0,  0, ALU_REG,   7,  6,  5,  32'd0,        1, 1, 1, 0, 1},  // sub  x7,x6,x5
        '{32'hFFC3A403, 0,  0, LOAD,      8,  7,  28, 32'hFFFFFFFC, 1, 0, 1, 2, 1},  // lw   x8,-4(x7)
        '{32'h00812423, 0,  0, STORE,     8,  2,  8,  32'd8,        1, 1, 0, 2, 0},  // sw   x8,8(x2)
        '{32'hFE008CE3, 0,  0, BRANCH,    25, 1,  0,  32'hFFFFFFF8, 1, 1, 0, 0, 1},  // beq  x1,x0,-8
        '{32'h010000EF, 0,  0, JUMP,      1,  0,  16, 32'd16,       0, 0, 1, 0, 0},  // jal  x1,16
        '{32'h00008067, 0,  0, JUMP,      0,  1,  0,  32'd0,        1, 0, 0, 0, 0},  // jalr x0,0(x1)
        '{32'h12345537, 0,  0, LUI_AUIPC, 10, 8,  3,  32'h12345000, 0, 0, 1, 5, 0},  // lui  x10
        '{32'hFFFFFFFF, 0,  0, ILLEGAL,   31, 31, 31, 32'd0,        0, 0, 0, 7, 1},
        '{32'h00128013, 0,  0, ALU_IMM,   0,  5,  1,  32'd1,        1, 0, 0, 0, 0},  // rd x0
        '{32'h000005B3, 0,  0, ALU_REG,   11, 0,  0,  32'd0,        1, 1, 1, 0, 0},  // reads x0
        '{32'h00700693, 0,  0, ALU_IMM,   13, 0,  7,  32'd7,        1, 0, 1, 0, 0},  // addi x13
        '{32'h00D68733, 0,  0, ALU_REG,   14, 13, 13, 32'd0,        1, 1, 1, 0, 0},  // waits on x13
        '{32'h000687B3, 0,  1, ALU_REG,   15, 13, 0,  32'd0,        1, 1, 1, 0, 0},  // after flush
        '{32'h00001817, 0,  0, LUI_AUIPC, 16, 0,  0,  32'h00001000, 0, 0, 1, 1, 0},  // auipc x16
        '{32'h0000006F, 0,  0, JUMP,      0,  0,  0,  32'd0,        0, 0, 0, 0, 0}   // jal x0,0
    };

    logic         clk, rstn;
    fetch_t       fetch_i;
    logic         flush_i;
    logic         exec_stall_i;
    wb_t          wb_i;
    logic         fetch_ready_o;
    id_ir_stage_t issue_o;

    int    errors = 0;
    int    tests = 0;
    int    cycle = 0;
    int    cur_idx = 0;                   // Row on fetch_i
    int    stall_req = 0;
    int    stall_left = 0;
    int    exp_q [$];                     // Accepted rows not yet issued
    int    wb_due [$];
    int    wb_rd [$];
    bit    busy_m [32];                   // Scoreboard model, pre-edge view
    bit    busy_dec [32];                 // State seen by the last issue decision
    bit    prev_ready = 0;
    bit    bp_seen = 0;                   // Ready fell under a stall at least once

    clk_rst_gen i_clk_rst_gen (.clk_o(clk), .rstn_o(rstn));

    decode_issue_top #(.IQ_DEPTH(IQ_DEPTH)) i_decode_issue_top (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .fetch_i       (fetch_i),
        .flush_i       (flush_i),
        .exec_stall_i  (exec_stall_i),
        .wb_i          (wb_i),
        .fetch_ready_o (fetch_ready_o),
        .issue_o       (issue_o)
    );

    bind decode_issue_top decode_issue_properties i_decode_issue_properties (
        .clk_i(clk_i), .rstn_i(rstn_i), .read_head_i(read_head), .empty_i(iq_empty),
        .full_i(iq_full), .head_i(iq_head), .issue_i(issue_o),
        .busy_i(i_issue_stage.busy_q)
    );

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, inout bit ok);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
            ok = 0;
        end
    endtask

    // Stall length bookkeeping on the rising edge, driven on the falling one
    always @(posedge clk) begin
        if (stall_req > 0) begin
            stall_left = stall_req;
            stall_req  = 0;
        end else if (stall_left > 0) begin
            stall_left--;
        end
    end

    always @(negedge clk) begin
        exec_stall_i = (stall_left > 0);
        wb_i = '0;
        if (wb_due.size() > 0 && wb_due[0] <= cycle) begin
            wb_i.valid = 1'b1;                     // One pulse per issued writer
            wb_i.rd    = reg_addr_t'(wb_rd[0]);
            void'(wb_due.pop_front());
            void'(wb_rd.pop_front());
        end
    end

    // Monitor and reference model, samples pre-edge values
    always @(posedge clk) begin
        int idx;
        bit ok;
        cycle++;
        if (cycle > LIMIT) begin
            $display("timeout after %0d cycles with %0d rows pending", cycle, exp_q.size());
            $display("Done: errors found");
            $finish;
        end else if (rstn) begin
            if (issue_o.instr.valid) begin
                if (exp_q.size() == 0) begin
                    $display("issue_o valid with no accepted instruction pending");
                    errors++;
                end else begin
                    idx = exp_q.pop_front();
                    ok  = 1;
                    compare_field("pc", issue_o.instr.pc, 32'h1000 + 4 * idx, ok);
                    compare_field("kind", 32'(issue_o.instr.kind), 32'(tbl[idx].kind), ok);
                    compare_field("rd", 32'(issue_o.instr.rd), 32'(tbl[idx].rd), ok);
                    compare_field("rs1", 32'(issue_o.instr.rs1), 32'(tbl[idx].rs1), ok);
                    compare_field("rs2", 32'(issue_o.instr.rs2), 32'(tbl[idx].rs2), ok);
                    compare_field("imm", issue_o.instr.imm, tbl[idx].imm, ok);
                    compare_field("use_rs1", 32'(issue_o.instr.use_rs1), 32'(tbl[idx].u1), ok);
                    compare_field("use_rs2", 32'(issue_o.instr.use_rs2), 32'(tbl[idx].u2), ok);
                    compare_field("we_rd", 32'(issue_o.instr.we_rd), 32'(tbl[idx].we), ok);
                    compare_field("funct3", 32'(issue_o.funct3), 32'(tbl[idx].f3), ok);
                    compare_field("funct7_5", 32'(issue_o.funct7_5), 32'(tbl[idx].f7), ok);
                    if ((tbl[idx].u1 && busy_dec[tbl[idx].rs1]) ||
                        (tbl[idx].u2 && busy_dec[tbl[idx].rs2])) begin
                        $display("row %0d issued before its source was written back", idx);
                        errors++;
                        ok = 0;
                    end
                    tests++;
                    $display("row %0d issued %s", idx, ok ? "ok" : "with errors");
                    if (tbl[idx].we) begin
                        busy_m[tbl[idx].rd] = 1;  // Set at the edge before this one
                        wb_due.push_back(cycle + 3);
                        wb_rd.push_back(int'(tbl[idx].rd));
                    end
                end
            end
            busy_dec = busy_m;
            if (wb_i.valid) busy_m[wb_i.rd] = 0;

            // Decode register plus a full queue
            if (prev_ready && !fetch_ready_o && exec_stall_i) begin
                tests++;
                bp_seen = 1;
                if (exp_q.size() != IQ_DEPTH + 1) begin
                    $display("fetch_ready_o fell with %0d words held, expected %0d",
                             exp_q.size(), IQ_DEPTH + 1);
                    errors++;
                end else begin
                    $display("back-pressure ok at %0d held words", exp_q.size());
                end
            end
            prev_ready = fetch_ready_o;

            if (flush_i) begin
                while (exp_q.size() > 0) begin
                    $display("row %0d flushed", exp_q.pop_front());
                end
            end else if (fetch_i.valid && fetch_ready_o) begin
                exp_q.push_back(cur_idx);
            end
        end
    end

    initial begin
        int gap;
        bit ok;
        fetch_i      = '0;
        flush_i      = 1'b0;
        exec_stall_i = 1'b0;
        wb_i         = '0;
        void'($urandom(14471));
        ok = 1;
        @(negedge clk);                   // Still inside reset
        compare_field("fetch_ready_o", 32'(fetch_ready_o), 32'h0, ok);
        compare_field("issue_o.instr.valid", 32'(issue_o.instr.valid), 32'h0, ok);
        wait (rstn === 1'b1);
        @(negedge clk);
        tests++;
        compare_field("fetch_ready_o", 32'(fetch_ready_o), 32'h1, ok);
        compare_field("issue_o.instr.valid", 32'(issue_o.instr.valid), 32'h0, ok);
        $display("reset %s", ok ? "ok" : "with errors");

        for (int i = 0; i < N_ROWS; i++) begin
            gap = (stall_left > 0 || stall_req > 0) ? 0 : $urandom % 3;
            repeat (gap) @(negedge clk);
            if (tbl[i].flush) begin
                // Let the older writer issue first, its reader stays queued
                while (exp_q.size() > 1) @(negedge clk);
                flush_i = 1'b1;
                @(negedge clk);
                flush_i = 1'b0;
            end
            cur_idx       = i;
            fetch_i.valid = 1'b1;
            fetch_i.pc    = 32'h1000 + 4 * i;
            fetch_i.word  = tbl[i].word;
            if (tbl[i].stall > 0) stall_req = tbl[i].stall;
            while (!fetch_ready_o) @(negedge clk);  // Ready stable until the edge
            @(negedge clk);
            fetch_i = '0;
        end

        while (exp_q.size() > 0 || wb_due.size() > 0) @(negedge clk);
        repeat (4) @(negedge clk);
        if (!bp_seen) begin
            $display("fetch_ready_o never fell while execute was stalled");
            errors++;
        end
        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
common/drac_pkg.sv
src/decode_stage.sv
instruction_queue/instruction_queue.sv
src/issue_stage.sv
src/decode_issue_top.sv
sim/clk_rst_gen.sv
sim/decode_issue_properties.sv
sim/tb_decode_issue.sv

// ==== Makefile ====
TOP = tb_decode_issue

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir

run: build
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
